//--- burst_counter.sv
module burst_counter #(
	parameter logic [31:0] BASE_ADDR  = 32'h0000_0000,
	parameter logic [31:0] WORD_COUNT = 32'd1
) (
	input	logic			rxbyteclkhs,
	input	logic			wb_rst_o,
	input	logic			load_i,
	input	logic			step_i,
	output	logic [31:0]	addr_o,
	output	logic			last_o,
	output	logic [31:0]	words_o
);

	logic [31:0]	addr_q;
	logic [31:0]	words_q;	// words written this run

	// ------------------------------
	//  address and count
	// ------------------------------

	always_ff @(posedge rxbyteclkhs) begin
		if (wb_rst_o) begin
			addr_q  <= '0;
			words_q <= '0;
		end else if (load_i) begin
			addr_q  <= BASE_ADDR;
			words_q <= '0;
		end else if (step_i) begin
			addr_q  <= addr_q + 32'd4;	// one 32-bit word
			words_q <= words_q + 32'd1;
		end
	end

	// current word is the final one of the run
	assign last_o  = (words_q == WORD_COUNT - 32'd1);

	assign addr_o  = addr_q;
	assign words_o = words_q;

endmodule

//--- capture_fifo.sv
module capture_fifo #(
	parameter int DEPTH = 16
) (
	input	logic						rxbyteclkhs,
	input	logic						wb_rst_o,
	input	logic						push_i,
	input	dphy_pkg::capture_word_t	data_i,
	input	logic						pop_i,
	output	dphy_pkg::capture_word_t	data_o,
	output	logic						empty_o,
	input	logic						ovf_clear_i,
	output	logic						overflow_o
);
	import dphy_pkg::*;

	localparam int AW = $clog2(DEPTH);

	capture_word_t	mem [DEPTH];
	logic [AW:0]	wr_ptr_q;	// extra msb tells full from empty
	logic [AW:0]	rd_ptr_q;
	logic			full;
	logic			do_push;
	logic			do_pop;
	logic			ovf_q;

	assign empty_o = (wr_ptr_q == rd_ptr_q);
	assign full    = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
	                 (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

	assign do_push = push_i & ~full;
	assign do_pop  = pop_i & ~empty_o;

	always_ff @(posedge rxbyteclkhs) begin
		if (do_push) begin
			mem[wr_ptr_q[AW-1:0]] <= data_i;
		end
	end

	always_ff @(posedge rxbyteclkhs) begin
		if (wb_rst_o) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			ovf_q    <= 1'b0;
		end else begin
			if (do_push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (do_pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			// a fresh drop wins over a clear in the same cycle
			if (push_i && full) begin
				ovf_q <= 1'b1;
			end else if (ovf_clear_i) begin
				ovf_q <= 1'b0;
			end
		end
	end

	assign data_o     = mem[rd_ptr_q[AW-1:0]];	// fall-through head
	assign overflow_o = ovf_q;

endmodule

//--- dma_write_fsm.sv
module dma_write_fsm (
	input	logic						rxbyteclkhs,
	input	logic						wb_rst_o,
	input	logic						start_i,
	input	logic						fifo_empty_i,
	input	dphy_pkg::capture_word_t	fifo_data_i,
	output	logic						fifo_pop_o,
	output	logic						cnt_load_o,
	output	logic						cnt_step_o,
	input	logic [31:0]				addr_i,
	input	logic						last_i,
	output	wb_pkg::mem_req_t			mem_req_o,
	output	logic						mem_req_valid_o,
	input	logic						mem_ack_i,
	output	logic						busy_o
);
	import wb_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT_DATA,
		ST_REQ_HIGH,
		ST_WAIT_ACK_LOW
	} state_t;

	state_t		state_q;
	mem_req_t	req_q;
	logic		req_valid_q;
	logic		take_word;
	logic		ack_fell;

	assign take_word = (state_q == ST_WAIT_DATA) && !fifo_empty_i;
	assign ack_fell  = (state_q == ST_WAIT_ACK_LOW) && !mem_ack_i;

	// ------------------------------
	//  state machine
	// ------------------------------

	always_ff @(posedge rxbyteclkhs) begin
		if (wb_rst_o) begin
			state_q     <= ST_IDLE;
			req_valid_q <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (start_i) begin	// start while busy never reaches here
						state_q <= ST_WAIT_DATA;
					end
				end
				ST_WAIT_DATA: begin
					if (take_word) begin
						req_valid_q <= 1'b1;
						state_q     <= ST_REQ_HIGH;
					end
				end
				ST_REQ_HIGH: begin
					if (mem_ack_i) begin
						req_valid_q <= 1'b0;
						state_q     <= ST_WAIT_ACK_LOW;
					end
				end
				ST_WAIT_ACK_LOW: begin
					// word done once ack is back low
					if (!mem_ack_i) begin
						state_q <= last_i ? ST_IDLE : ST_WAIT_DATA;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// request payload held until req drops
	always_ff @(posedge rxbyteclkhs) begin
		if (take_word) begin
			req_q.addr <= addr_i;
			req_q.data <= fifo_data_i;
		end
	end

	assign cnt_load_o      = (state_q == ST_IDLE) && start_i;
	assign fifo_pop_o      = ack_fell;
	assign cnt_step_o      = ack_fell;
	assign mem_req_o       = req_q;
	assign mem_req_valid_o = req_valid_q;
	assign busy_o          = (state_q != ST_IDLE);

endmodule

//--- dphy_pkg.sv
package dphy_pkg;

	// ------------------------------
	//  lane side
	// ------------------------------

	// byte clock outputs of one data lane
	typedef struct packed {
		logic	[7:0]	rxdatahs;
		logic			rxvalidhs;
		logic			rxactivehs;
		logic			rxsynchs;
		logic			errsoths;
		logic			errsotsynchs;
	} lane_sample_t;

	localparam int LANE_HALF_W = 16;
	localparam int LANE_PAD_W  = LANE_HALF_W - $bits(lane_sample_t);
	localparam int LANE_CNT_W  = 32;	// per-lane byte counter

	// ------------------------------
	//  capture word
	// ------------------------------

	typedef struct packed {
		logic	[LANE_PAD_W-1:0]	pad;			// always zero
		logic						errsotsynchs;	// bit 12
		logic						errsoths;
		logic						rxsynchs;
		logic						rxactivehs;
		logic						rxvalidhs;		// bit 8
		logic	[7:0]				rxdatahs;
	} lane_half_t;

	typedef struct packed {
		lane_half_t	lane1;	// high half
		lane_half_t	lane0;	// low half
	} capture_word_t;

	function automatic lane_half_t pack_lane(input lane_sample_t s);
		lane_half_t h;
		h.pad          = '0;
		h.errsotsynchs = s.errsotsynchs;
		h.errsoths     = s.errsoths;
		h.rxsynchs     = s.rxsynchs;
		h.rxactivehs   = s.rxactivehs;
		h.rxvalidhs    = s.rxvalidhs;
		h.rxdatahs     = s.rxdatahs;
		return h;
	endfunction

endpackage

//--- lane_capture.sv
module lane_capture (
	input	logic								rxbyteclkhs,
	input	logic								wb_rst_o,
	input	dphy_pkg::lane_sample_t				lane0_i,
	input	dphy_pkg::lane_sample_t				lane1_i,
	input	logic								busy_i,
	output	dphy_pkg::capture_word_t			word_o,
	output	logic								word_push_o,
	output	logic [dphy_pkg::LANE_CNT_W-1:0]	lane0_cnt_o,
	output	logic [dphy_pkg::LANE_CNT_W-1:0]	lane1_cnt_o
);
	import dphy_pkg::*;

	lane_sample_t			lane_in [2];
	lane_sample_t			lane_q [2];		// one cycle sample
	logic [LANE_CNT_W-1:0]	cnt_q [2];

	assign lane_in[0] = lane0_i;
	assign lane_in[1] = lane1_i;

	// ------------------------------
	//  sample and count
	// ------------------------------

	always_ff @(posedge rxbyteclkhs) begin
		if (wb_rst_o) begin
			for (int i = 0; i < 2; i++) begin
				lane_q[i] <= '0;
				cnt_q[i]  <= '0;
			end
		end else begin
			for (int i = 0; i < 2; i++) begin
				lane_q[i] <= lane_in[i];
				// sync restarts the count, even with active set
				if (lane_in[i].rxsynchs) begin
					cnt_q[i] <= '0;
				end else if (lane_in[i].rxactivehs) begin
					cnt_q[i] <= cnt_q[i] + 1'b1;
				end
			end
		end
	end

	// ------------------------------
	//  word packing
	// ------------------------------

	assign word_o.lane0 = pack_lane(lane_q[0]);
	assign word_o.lane1 = pack_lane(lane_q[1]);

	// fifo write happens on the next edge
	assign word_push_o = busy_i & (lane_q[0].rxvalidhs | lane_q[1].rxvalidhs);

	assign lane0_cnt_o = cnt_q[0];
	assign lane1_cnt_o = cnt_q[1];

endmodule

//--- mipi_capture_top.sv
module mipi_capture_top #(
	parameter logic [31:0] GID        = 32'h0000_0000,
	parameter logic [31:0] BASE_ADDR  = 32'h1000_0000,
	parameter logic [31:0] WORD_COUNT = 32'd8,
	parameter int          FIFO_DEPTH = 16
) (
	input	logic						rxbyteclkhs,
	input	logic						wb_rst_o,
	input	dphy_pkg::lane_sample_t		lane0_i,
	input	dphy_pkg::lane_sample_t		lane1_i,
	input	wb_pkg::wb_req_t			wb_req_i,
	output	wb_pkg::wb_rsp_t			wb_rsp_o,
	output	wb_pkg::mem_req_t			mem_req_o,
	output	logic						mem_req_valid_o,
	input	logic						mem_ack_i
);
	import dphy_pkg::*;

	capture_word_t			cap_word;
	logic					cap_push;
	capture_word_t			fifo_data;
	logic					fifo_pop;
	logic					fifo_empty;
	logic					overflow;
	logic					ovf_clear;
	logic [LANE_CNT_W-1:0]	lane0_cnt;
	logic [LANE_CNT_W-1:0]	lane1_cnt;
	logic					busy;
	logic					start;
	logic					cnt_load;
	logic					cnt_step;
	logic [31:0]			wr_addr;
	logic					wr_last;
	logic [31:0]			words;

	// ------------------------------
	//  capture path
	// ------------------------------

	lane_capture lane_capture_i (
		.rxbyteclkhs	(rxbyteclkhs),
		.wb_rst_o		(wb_rst_o),
		.lane0_i		(lane0_i),
		.lane1_i		(lane1_i),
		.busy_i			(busy),
		.word_o			(cap_word),
		.word_push_o	(cap_push),
		.lane0_cnt_o	(lane0_cnt),
		.lane1_cnt_o	(lane1_cnt)
	);

	capture_fifo #(
		.DEPTH			(FIFO_DEPTH)
	) capture_fifo_i (
		.rxbyteclkhs	(rxbyteclkhs),
		.wb_rst_o		(wb_rst_o),
		.push_i			(cap_push),
		.data_i			(cap_word),
		.pop_i			(fifo_pop),
		.data_o			(fifo_data),
		.empty_o		(fifo_empty),
		.ovf_clear_i	(ovf_clear),
		.overflow_o		(overflow)
	);

	// ------------------------------
	//  memory writer
	// ------------------------------

	burst_counter #(
		.BASE_ADDR		(BASE_ADDR),
		.WORD_COUNT		(WORD_COUNT)
	) burst_counter_i (
		.rxbyteclkhs	(rxbyteclkhs),
		.wb_rst_o		(wb_rst_o),
		.load_i			(cnt_load),
		.step_i			(cnt_step),
		.addr_o			(wr_addr),
		.last_o			(wr_last),
		.words_o		(words)
	);

	dma_write_fsm dma_write_fsm_i (
		.rxbyteclkhs		(rxbyteclkhs),
		.wb_rst_o			(wb_rst_o),
		.start_i			(start),
		.fifo_empty_i		(fifo_empty),
		.fifo_data_i		(fifo_data),
		.fifo_pop_o			(fifo_pop),
		.cnt_load_o			(cnt_load),
		.cnt_step_o			(cnt_step),
		.addr_i				(wr_addr),
		.last_i				(wr_last),
		.mem_req_o			(mem_req_o),
		.mem_req_valid_o	(mem_req_valid_o),
		.mem_ack_i			(mem_ack_i),
		.busy_o				(busy)
	);

	// host registers
	wb_regs #(
		.GID			(GID)
	) wb_regs_i (
		.rxbyteclkhs	(rxbyteclkhs),
		.wb_rst_o		(wb_rst_o),
		.wb_req_i		(wb_req_i),
		.wb_rsp_o		(wb_rsp_o),
		.busy_i			(busy),
		.overflow_i		(overflow),
		.lane0_cnt_i	(lane0_cnt),
		.lane1_cnt_i	(lane1_cnt),
		.words_i		(words),
		.start_o		(start),
		.ovf_clear_o	(ovf_clear)
	);

endmodule

//--- tb_mipi_capture.sv
module tb_mipi_capture;
	import dphy_pkg::*;
	import wb_pkg::*;

	localparam logic [31:0] GID_VAL    = 32'h0123_4567;
	localparam logic [31:0] BASE_ADDR  = 32'h1000_0000;
	localparam int          WORD_COUNT = 8;
	localparam int          FIFO_DEPTH = 4;
	localparam int          MAX_CYCLES = 4000;	// about four times the summed test lengths
	localparam logic [19:0] PAGE_NONE  = 20'h12345;	// nothing mapped here
	localparam int          LANE0_K    = 5;
	localparam int          LANE1_M    = 7;

	logic			rxbyteclkhs = 1'b0;
	logic			wb_rst_o;
	lane_sample_t	lane0_i;
	lane_sample_t	lane1_i;
	wb_req_t		wb_req_i;
	wb_rsp_t		wb_rsp_o;
	mem_req_t		mem_req_o;
	logic			mem_req_valid_o;
	logic			mem_ack_i;

	int				errors;
	int				checks;
	int				cycle_cnt;
	int				ack_base;		// responder delay in cycles
	int				ack_jitter;
	logic [31:0]	lane1_model;
	logic [31:0]	log_addr [$];
	logic [31:0]	log_data [$];
	logic [31:0]	driven [$];		// words put on the lanes with valid

	mipi_capture_top #(
		.GID			(GID_VAL),
		.BASE_ADDR		(BASE_ADDR),
		.WORD_COUNT		(WORD_COUNT),
		.FIFO_DEPTH		(FIFO_DEPTH)
	) mipi_capture_top_i (
		.rxbyteclkhs		(rxbyteclkhs),
		.wb_rst_o			(wb_rst_o),
		.lane0_i			(lane0_i),
		.lane1_i			(lane1_i),
		.wb_req_i			(wb_req_i),
		.wb_rsp_o			(wb_rsp_o),
		.mem_req_o			(mem_req_o),
		.mem_req_valid_o	(mem_req_valid_o),
		.mem_ack_i			(mem_ack_i)
	);

	always #5 rxbyteclkhs = ~rxbyteclkhs;

	// ------------------------------
	//  memory responder
	// ------------------------------

	initial begin
		int wait_n;
		mem_ack_i = 1'b0;
		forever begin
			@(negedge rxbyteclkhs);
			if (mem_req_valid_o && !mem_ack_i) begin
				log_addr.push_back(mem_req_o.addr);
				log_data.push_back(mem_req_o.data);
				wait_n = ack_base + int'($urandom % (ack_jitter + 1));
				repeat (wait_n) @(negedge rxbyteclkhs);
				@(posedge rxbyteclkhs);
				mem_ack_i <= 1'b1;
				do begin
					@(negedge rxbyteclkhs);
				end while (mem_req_valid_o);	// hold ack until req drops
				@(posedge rxbyteclkhs);
				mem_ack_i <= 1'b0;
			end
		end
	end

	// watchdog
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < MAX_CYCLES) begin
			@(posedge rxbyteclkhs);
			cycle_cnt++;
		end
		$display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	// ------------------------------
	//  helpers
	// ------------------------------

	task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	function automatic logic [29:0] reg_adr(input logic [19:0] page, input logic [7:0] offset);
		return {page, 2'b00, offset};
	endfunction

	task automatic wb_read(input logic [29:0] adr, output logic [31:0] dat, output logic ack);
		wb_req_t r;
		r     = '0;
		r.adr = adr;
		r.stb = 1'b1;
		@(posedge rxbyteclkhs);
		wb_req_i <= r;
		@(negedge rxbyteclkhs);	// response is combinational
		dat = wb_rsp_o.dat;
		ack = wb_rsp_o.ack;
		@(posedge rxbyteclkhs);
		wb_req_i <= '0;
	endtask

	task automatic wb_write(input logic [29:0] adr, input logic [31:0] dat);
		wb_req_t r;
		r     = '0;
		r.adr = adr;
		r.dat = dat;
		r.we  = 1'b1;
		r.sel = 4'hf;
		r.stb = 1'b1;
		@(posedge rxbyteclkhs);
		wb_req_i <= r;
		@(posedge rxbyteclkhs);
		wb_req_i <= '0;
	endtask

	task automatic read_reg(input logic [7:0] offset, output logic [31:0] dat);
		logic ack;
		wb_read(reg_adr(WB_PAGE_DMA, offset), dat, ack);
	endtask

	// each half holds the byte, then valid, active, sync, errsoths, errsotsynchs and zero pad
	function automatic logic [31:0] expected_word(input lane_sample_t l0, input lane_sample_t l1);
		return {3'b000, l1.errsotsynchs, l1.errsoths, l1.rxsynchs, l1.rxactivehs,
		        l1.rxvalidhs, l1.rxdatahs,
		        3'b000, l0.errsotsynchs, l0.errsoths, l0.rxsynchs, l0.rxactivehs,
		        l0.rxvalidhs, l0.rxdatahs};
	endfunction

	function automatic lane_sample_t random_sample(input logic with_sync);
		lane_sample_t s;
		s              = '0;
		s.rxdatahs     = 8'($urandom);
		s.rxvalidhs    = 1'b1;
		s.rxactivehs   = 1'($urandom);
		s.rxsynchs     = with_sync & 1'($urandom);
		s.errsoths     = 1'($urandom);
		s.errsotsynchs = 1'($urandom);
		return s;
	endfunction

	task automatic drive_lanes(input lane_sample_t l0, input lane_sample_t l1);
		@(posedge rxbyteclkhs);
		lane0_i <= l0;
		lane1_i <= l1;
		// sync clears the lane 1 model before active counts
		if (l1.rxsynchs) begin
			lane1_model = '0;
		end else if (l1.rxactivehs) begin
			lane1_model = lane1_model + 1;
		end
		if (l0.rxvalidhs || l1.rxvalidhs) begin
			driven.push_back(expected_word(l0, l1));
		end
	endtask

	task automatic idle_lanes(input int n);
		repeat (n) drive_lanes('0, '0);
	endtask

	task automatic wait_for_busy(input logic level);
		logic [31:0] d;
		do begin
			read_reg(REG_CTRL, d);
		end while (d[0] !== level);
	endtask

	task automatic start_run();
		wb_write(reg_adr(WB_PAGE_DMA, REG_CTRL), 32'd1);
		wait_for_busy(1'b1);
	endtask

	// spaced valid words until the run is over
	task automatic capture_until_idle(input int gap);
		logic [31:0] d;
		d = 32'd1;
		while (d[0]) begin
			drive_lanes(random_sample(1'b1), random_sample(1'b0));
			idle_lanes(gap);
			read_reg(REG_CTRL, d);
		end
	endtask

	task automatic clear_logs();
		log_addr.delete();
		log_data.delete();
		driven.delete();
	endtask

	task automatic check_addresses();
		check_eq("write count", log_addr.size(), WORD_COUNT);
		for (int i = 0; i < log_addr.size(); i++) begin
			check_eq($sformatf("write %0d address", i), log_addr[i], BASE_ADDR + 4 * i);
		end
	endtask

	// ------------------------------
	//  tests
	// ------------------------------

	task automatic test_reset_state();
		logic [31:0]	d;
		logic			ack;
		@(negedge rxbyteclkhs);
		checks++;
		if (mem_req_valid_o !== 1'b0) begin
			errors++;
			$display("[ERROR] %0t: memory request is high after reset", $time);
		end
		wb_read(reg_adr(WB_PAGE_DMA, REG_CTRL), d, ack);
		check_eq("REG_CTRL", d, 32'd0);
		check_eq("REG_CTRL ack", ack, 32'd1);
		wb_read(reg_adr(WB_PAGE_GID, 8'h5a), d, ack);
		check_eq("GID", d, GID_VAL);
		check_eq("GID ack", ack, 32'd1);
		wb_read(reg_adr(PAGE_NONE, 8'h00), d, ack);
		check_eq("unmapped read", d, 32'd0);
		check_eq("unmapped ack", ack, 32'd1);
		wb_read(reg_adr(WB_PAGE_DMA, 8'h20), d, ack);
		check_eq("unused DMA offset", d, 32'd0);
	endtask

	task automatic test_zero_delay_run();
		logic [31:0] d;
		ack_base   = 0;
		ack_jitter = 0;
		clear_logs();
		start_run();
		for (int i = 0; i < WORD_COUNT; i++) begin
			drive_lanes(random_sample(1'b1), random_sample(1'b0));
			idle_lanes(10);	// longer than one write
			if (i == WORD_COUNT / 2) begin
				read_reg(REG_CTRL, d);
				check_eq("busy during run", d[0], 32'd1);
			end
		end
		wait_for_busy(1'b0);
		check_addresses();
		for (int i = 0; i < log_data.size() && i < driven.size(); i++) begin
			check_eq($sformatf("write %0d data", i), log_data[i], driven[i]);
		end
		read_reg(REG_WORDS, d);
		check_eq("REG_WORDS", d, WORD_COUNT);
	endtask

	task automatic test_lane_counters();
		logic [31:0]	d;
		logic [31:0]	lane1_before;
		lane_sample_t	s0;
		lane_sample_t	s1;
		lane1_before  = lane1_model;
		s0            = '0;
		s0.rxsynchs   = 1'b1;
		s0.rxactivehs = 1'b1;	// sync has to win
		drive_lanes(s0, '0);
		for (int i = 0; i < LANE1_M; i++) begin
			s0            = '0;
			s1            = '0;
			s0.rxactivehs = (i < LANE0_K);
			s1.rxactivehs = 1'b1;
			s0.rxdatahs   = 8'($urandom);
			s1.rxdatahs   = 8'($urandom);
			drive_lanes(s0, s1);
		end
		idle_lanes(1);
		read_reg(REG_LANE0_CNT, d);
		check_eq("REG_LANE0_CNT", d, LANE0_K);
		read_reg(REG_LANE1_CNT, d);
		check_eq("REG_LANE1_CNT", d, lane1_before + LANE1_M);
	endtask

	task automatic test_overflow();
		logic [31:0]	d;
		int				j;
		ack_base   = 30;
		ack_jitter = 7;
		clear_logs();
		start_run();
		repeat (12) drive_lanes(random_sample(1'b1), random_sample(1'b0));
		idle_lanes(2);
		read_reg(REG_CTRL, d);
		check_eq("overflow after burst", d[1], 32'd1);
		capture_until_idle(40);
		check_addresses();
		// written words keep the driven order with gaps allowed
		j = 0;
		foreach (log_data[i]) begin
			while (j < driven.size() && driven[j] !== log_data[i]) begin
				j++;
			end
			checks++;
			if (j >= driven.size()) begin
				errors++;
				$display("[ERROR] %0t: write %0d data %h is out of driven order",
				         $time, i, log_data[i]);
			end
			j++;
		end
		read_reg(REG_CTRL, d);
		check_eq("REG_CTRL at run end", d, 32'h2);
		wb_write(reg_adr(WB_PAGE_DMA, REG_CTRL), 32'd0);
		read_reg(REG_CTRL, d);
		check_eq("REG_CTRL after clear", d, 32'd0);
	endtask

	task automatic test_start_while_busy();
		logic [31:0] d;
		ack_base   = 0;
		ack_jitter = 3;
		clear_logs();
		start_run();
		wb_write(reg_adr(WB_PAGE_DMA, REG_CTRL), 32'd1);	// ignored while the run goes on
		capture_until_idle(10);
		check_addresses();
		read_reg(REG_WORDS, d);
		check_eq("REG_WORDS after first run", d, WORD_COUNT);
		clear_logs();
		start_run();
		capture_until_idle(10);
		check_addresses();
	endtask

	initial begin
		void'($urandom(32'h7b429467));
		errors      = 0;
		checks      = 0;
		ack_base    = 0;
		ack_jitter  = 0;
		lane1_model = '0;
		wb_rst_o    = 1'b1;
		lane0_i     = '0;
		lane1_i     = '0;
		wb_req_i    = '0;
		repeat (3) @(posedge rxbyteclkhs);
		wb_rst_o <= 1'b0;

		test_reset_state();
		test_zero_delay_run();
		test_lane_counters();
		test_overflow();
		test_start_while_busy();

		$display("tests done: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- verilog.f
dphy_pkg.sv
wb_pkg.sv
lane_capture.sv
capture_fifo.sv
burst_counter.sv
dma_write_fsm.sv
wb_regs.sv
mipi_capture_top.sv
tb_mipi_capture.sv

//--- wb_pkg.sv
package wb_pkg;
	import dphy_pkg::capture_word_t;

	// host request, word addressed
	typedef struct packed {
		logic	[29:0]	adr;
		logic	[31:0]	dat;
		logic			we;
		logic	[3:0]	sel;
		logic			stb;
	} wb_req_t;

	typedef struct packed {
		logic	[31:0]	dat;
		logic			ack;
	} wb_rsp_t;

	// single word memory write
	typedef struct packed {
		logic	[31:0]	addr;
		capture_word_t	data;
	} mem_req_t;

	// ------------------------------
	//  address map
	// ------------------------------

	localparam logic [19:0] WB_PAGE_GID = 20'h40000;	// adr[29:10]
	localparam logic [19:0] WB_PAGE_DMA = 20'h40010;

	localparam logic [7:0] REG_CTRL      = 8'd0;	// bit0 busy/start, bit1 overflow
	localparam logic [7:0] REG_LANE0_CNT = 8'd1;
	localparam logic [7:0] REG_LANE1_CNT = 8'd2;
	localparam logic [7:0] REG_WORDS     = 8'd3;

endpackage

//--- wb_regs.sv
module wb_regs #(
	parameter logic [31:0] GID = 32'h0000_0000
) (
	input	logic								rxbyteclkhs,
	input	logic								wb_rst_o,
	input	wb_pkg::wb_req_t					wb_req_i,
	output	wb_pkg::wb_rsp_t					wb_rsp_o,
	input	logic								busy_i,
	input	logic								overflow_i,
	input	logic [dphy_pkg::LANE_CNT_W-1:0]	lane0_cnt_i,
	input	logic [dphy_pkg::LANE_CNT_W-1:0]	lane1_cnt_i,
	input	logic [31:0]						words_i,
	output	logic								start_o,
	output	logic								ovf_clear_o
);
	import wb_pkg::*;

	logic			gid_hit;
	logic			dma_hit;
	logic [7:0]		offset;
	logic [31:0]	dma_dat;
	logic			ctrl_wr;
	logic			start_q;
	logic			ovf_clear_q;

	// ------------------------------
	//  address decode
	// ------------------------------

	assign gid_hit = wb_req_i.stb && (wb_req_i.adr[29:10] == WB_PAGE_GID);
	assign dma_hit = wb_req_i.stb && (wb_req_i.adr[29:10] == WB_PAGE_DMA);
	assign offset  = wb_req_i.adr[7:0];

	always_comb begin
		case (offset)
			REG_CTRL:      dma_dat = {30'd0, overflow_i, busy_i};
			REG_LANE0_CNT: dma_dat = lane0_cnt_i;
			REG_LANE1_CNT: dma_dat = lane1_cnt_i;
			REG_WORDS:     dma_dat = words_i;
			default:       dma_dat = '0;	// unused offsets
		endcase
	end

	assign wb_rsp_o.dat = gid_hit ? GID :
	                      dma_hit ? dma_dat :
	                      32'h0000_0000;
	assign wb_rsp_o.ack = wb_req_i.stb;	// every address acks at once

	// ------------------------------
	//  control pulses
	// ------------------------------

	assign ctrl_wr = dma_hit && wb_req_i.we && wb_req_i.sel[0] && (offset == REG_CTRL);

	always_ff @(posedge rxbyteclkhs) begin
		if (wb_rst_o) begin
			start_q     <= 1'b0;
			ovf_clear_q <= 1'b0;
		end else begin
			start_q     <= ctrl_wr && wb_req_i.dat[0] && !busy_i;
			ovf_clear_q <= ctrl_wr;	// any ctrl write clears overflow
		end
	end

	assign start_o     = start_q;
	assign ovf_clear_o = ovf_clear_q;

endmodule
